// File: soc_top.f
verilog/soc_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_decoder.sv
verilog/data_mem.sv
verilog/gpio.sv
verilog/rv_timer.sv
verilog/soc_top.sv
bench/tb_clock.sv
bench/soc_top_tb.sv

// File: Makefile
# Verilator build and run of the soc_top testbench

VERILATOR ?= verilator
TOP       ?= soc_top_tb
FLIST     ?= soc_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench into $(LOG) and check it"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Something failed" $(LOG); then echo "test FAILED"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "test FAILED, simulator exit $$status"; exit 1; fi; \
	echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/soc_top_tb.sv
`timescale 1ns/1ps

module soc_top_tb;

  localparam int DMEM_WORDS   = 256;
  localparam int GPIO_WIDTH   = 32;
  localparam int TIMER_N      = 40;
  // bus accesses issued by all tests together
  localparam int NUM_ACCESSES = 39;
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 10 + TIMER_N + 10;

  logic                       clk;
  logic                       rst_n;
  logic                       h0_req;
  logic                       h0_we;
  logic [31:0]                h0_addr;
  logic [soc_pkg::DATA_W-1:0] h0_wdata;
  logic                       h0_ack;
  logic [soc_pkg::DATA_W-1:0] h0_rdata;
  logic                       h0_err;
  logic                       h1_req;
  logic                       h1_we;
  logic [31:0]                h1_addr;
  logic [soc_pkg::DATA_W-1:0] h1_wdata;
  logic                       h1_ack;
  logic [soc_pkg::DATA_W-1:0] h1_rdata;
  logic                       h1_err;
  logic [GPIO_WIDTH-1:0]      gpio_in;
  logic [GPIO_WIDTH-1:0]      gpio_out;
  logic [GPIO_WIDTH-1:0]      gpio_oe;
  logic                       intr_gpio;
  logic                       intr_timer;

  int          cycle_cnt = 0;
  int          value_errors;
  int          other_errors;
  logic [15:0] lfsr_state;

  tb_clock #(
    .PERIOD_NS (4)
  ) i_clock (
    .clk_o (clk)
  );

  soc_top #(
    .DMEM_WORDS (DMEM_WORDS),
    .GPIO_WIDTH (GPIO_WIDTH)
  ) i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .h0_req_i     (h0_req),
    .h0_we_i      (h0_we),
    .h0_addr_i    (h0_addr),
    .h0_wdata_i   (h0_wdata),
    .h0_ack_o     (h0_ack),
    .h0_rdata_o   (h0_rdata),
    .h0_err_o     (h0_err),
    .h1_req_i     (h1_req),
    .h1_we_i      (h1_we),
    .h1_addr_i    (h1_addr),
    .h1_wdata_i   (h1_wdata),
    .h1_ack_o     (h1_ack),
    .h1_rdata_o   (h1_rdata),
    .h1_err_o     (h1_err),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .intr_gpio_o  (intr_gpio),
    .intr_timer_o (intr_timer)
  );

  // watchdog and cycle stamp for the bus tasks
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR timeout after %0d cycles, a bus handshake never completed", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  // galois lfsr stepped once per random bit
  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 16'hb400;
    end
    return lsb;
  endfunction

  function automatic logic [soc_pkg::DATA_W-1:0] random_word();
    logic [soc_pkg::DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < soc_pkg::DATA_W; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  // region in the top nibble and word index above the byte offset
  function automatic logic [31:0] make_addr(input logic [3:0] region, input logic [7:0] index);
    return {region, 18'h0, index, 2'b00};
  endfunction

  task automatic check_word(input string name, input logic [soc_pkg::DATA_W-1:0] expected,
                            input logic [soc_pkg::DATA_W-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %s expected %b actual %b", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      value_errors++;
      $display("FAIL %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic report_problem(input string what);
    other_errors++;
    $display("ERROR at cycle %0d: %s", cycle_cnt, what);
  endtask

  // one four-phase transaction on host 0 or host 1
  task automatic bus_access(input int host, input logic we, input logic [31:0] addr,
                            input logic [soc_pkg::DATA_W-1:0] wdata,
                            output logic [soc_pkg::DATA_W-1:0] rdata, output logic err,
                            output int lat, output int ack_at, output int end_at);
    logic ack;
    @(posedge clk);
    #1;
    if (host == 0) begin
      h0_we    = we;
      h0_addr  = addr;
      h0_wdata = wdata;
      h0_req   = 1'b1;
    end else begin
      h1_we    = we;
      h1_addr  = addr;
      h1_wdata = wdata;
      h1_req   = 1'b1;
    end
    lat = 0;
    ack = 1'b0;
    while (!ack) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
      ack = (host == 0) ? h0_ack : h1_ack;
    end
    ack_at = cycle_cnt;
    rdata  = (host == 0) ? h0_rdata : h1_rdata;
    err    = (host == 0) ? h0_err : h1_err;
    @(posedge clk);
    #1;
    if (host == 0) begin
      h0_req = 1'b0;
    end else begin
      h1_req = 1'b0;
    end
    while (ack) begin
      @(negedge clk);
      ack = (host == 0) ? h0_ack : h1_ack;
    end
    end_at = cycle_cnt;
  endtask

  task automatic write_word(input int host, input logic [31:0] addr,
                            input logic [soc_pkg::DATA_W-1:0] data, input string name);
    logic [soc_pkg::DATA_W-1:0] rdata;
    logic err;
    int lat;
    int ack_at;
    int end_at;
    bus_access(host, 1'b1, addr, data, rdata, err, lat, ack_at, end_at);
    check_flag({name, " write err"}, 1'b0, err);
  endtask

  task automatic read_word(input int host, input logic [31:0] addr, input string name,
                           output logic [soc_pkg::DATA_W-1:0] data);
    logic err;
    int lat;
    int ack_at;
    int end_at;
    bus_access(host, 1'b0, addr, '0, data, err, lat, ack_at, end_at);
    check_flag({name, " read err"}, 1'b0, err);
  endtask

  task automatic test_reset_state();
    check_flag("reset h0 ack", 1'b0, h0_ack);
    check_flag("reset h1 ack", 1'b0, h1_ack);
    check_flag("reset h0 err", 1'b0, h0_err);
    check_flag("reset h1 err", 1'b0, h1_err);
    check_flag("reset gpio intr", 1'b0, intr_gpio);
    check_flag("reset timer intr", 1'b0, intr_timer);
    check_word("reset gpio oe", '0, gpio_oe);
  endtask

  // runs first while host 0 still counts as served last
  task automatic test_arbitration();
    logic [soc_pkg::DATA_W-1:0] word0;
    logic [soc_pkg::DATA_W-1:0] word1;
    logic [soc_pkg::DATA_W-1:0] rd0;
    logic [soc_pkg::DATA_W-1:0] rd1;
    logic err0;
    logic err1;
    int lat0;
    int lat1;
    int ack0;
    int ack1;
    int end0;
    int end1;
    word0 = random_word();
    word1 = random_word();
    fork
      bus_access(0, 1'b1, make_addr(soc_pkg::REGION_DMEM, 8'd40), word0, rd0, err0, lat0,
                 ack0, end0);
      bus_access(1, 1'b1, make_addr(soc_pkg::REGION_DMEM, 8'd41), word1, rd1, err1, lat1,
                 ack1, end1);
    join
    check_count("arbitration host 1 latency", 2, lat1);
    check_flag("arbitration host 0 err", 1'b0, err0);
    check_flag("arbitration host 1 err", 1'b0, err1);
    if (ack1 >= ack0) begin
      report_problem("host 0 was acked before host 1 on the first tie");
    end
    if (ack0 <= end1) begin
      report_problem("host 0 saw ack while the host 1 transaction was still open");
    end
    read_word(1, make_addr(soc_pkg::REGION_DMEM, 8'd40), "arbitration", rd0);
    check_word("arbitration host 0 word", word0, rd0);
    read_word(0, make_addr(soc_pkg::REGION_DMEM, 8'd41), "arbitration", rd1);
    check_word("arbitration host 1 word", word1, rd1);
  endtask

  // write through one host and read back through the other
  task automatic test_memory();
    logic [soc_pkg::DATA_W-1:0] words [4];
    logic [soc_pkg::DATA_W-1:0] rdata;
    logic [31:0] addr;
    logic err;
    int lat;
    int ack_at;
    int end_at;
    for (int dir = 0; dir < 2; dir++) begin
      for (int i = 0; i < 4; i++) begin
        words[i] = random_word();
        addr = make_addr(soc_pkg::REGION_DMEM, 8'(8 + 8 * dir + i));
        bus_access(dir, 1'b1, addr, words[i], rdata, err, lat, ack_at, end_at);
        check_flag("memory write err", 1'b0, err);
        check_count("memory write latency", 2, lat);
      end
      for (int i = 0; i < 4; i++) begin
        addr = make_addr(soc_pkg::REGION_DMEM, 8'(8 + 8 * dir + i));
        bus_access(1 - dir, 1'b0, addr, '0, rdata, err, lat, ack_at, end_at);
        check_flag("memory read err", 1'b0, err);
        check_count("memory read latency", 2, lat);
        check_word("memory read data", words[i], rdata);
      end
    end
  endtask

  task automatic test_unmapped();
    logic [soc_pkg::DATA_W-1:0] rdata;
    logic err;
    int lat;
    int ack_at;
    int end_at;
    bus_access(0, 1'b1, make_addr(4'h7, 8'd3), random_word(), rdata, err, lat, ack_at, end_at);
    check_flag("unmapped write err", 1'b1, err);
    check_word("unmapped write rdata", '0, rdata);
    bus_access(1, 1'b0, make_addr(4'h7, 8'd3), '0, rdata, err, lat, ack_at, end_at);
    check_flag("unmapped read err", 1'b1, err);
    check_word("unmapped read rdata", '0, rdata);
  endtask

  task automatic test_gpio();
    logic [soc_pkg::DATA_W-1:0] out_val;
    logic [soc_pkg::DATA_W-1:0] oe_val;
    logic [soc_pkg::DATA_W-1:0] rd;
    out_val = random_word();
    oe_val  = random_word();
    write_word(0, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DATA_OUT), out_val, "gpio out");
    write_word(1, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OE), oe_val, "gpio oe");
    read_word(0, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DATA_OUT), "gpio out", rd);
    check_word("gpio data out readback", out_val, rd);
    read_word(1, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OE), "gpio oe", rd);
    check_word("gpio oe readback", oe_val, rd);
    check_word("gpio_o pins", out_val, gpio_out);
    check_word("gpio_oe_o pins", oe_val, gpio_oe);
    // only bits 4 and 5 of the edges below are enabled
    write_word(0, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_INTR_ENABLE), 32'h0000_00f0,
               "gpio enable");
    // edges on disabled bits first
    @(posedge clk);
    #1;
    gpio_in = 32'h0000_0003;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("gpio intr after disabled edge", 1'b0, intr_gpio);
    @(posedge clk);
    #1;
    gpio_in = 32'h0000_0033;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("gpio intr after edge", 1'b1, intr_gpio);
    read_word(1, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DATA_IN), "gpio in", rd);
    check_word("gpio data in", 32'h0000_0033, rd);
    read_word(0, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_INTR_STATE), "gpio state", rd);
    check_word("gpio intr state", 32'h0000_0033, rd);
    write_word(1, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_INTR_STATE), 32'h0000_0033,
               "gpio clear");
    read_word(0, make_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_INTR_STATE), "gpio state", rd);
    check_word("gpio intr state cleared", '0, rd);
    check_flag("gpio intr after clear", 1'b0, intr_gpio);
  endtask

  task automatic test_timer();
    logic [soc_pkg::DATA_W-1:0] prev;
    logic [soc_pkg::DATA_W-1:0] cnt;
    logic [soc_pkg::DATA_W-1:0] rd;
    logic err;
    int lat;
    int ack_at;
    int end_at;
    int waited;
    write_word(0, make_addr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CTRL), 32'd0, "timer off");
    write_word(0, make_addr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_COMPARE), 32'(TIMER_N),
               "timer compare");
    write_word(1, make_addr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_COUNT), 32'd0, "timer count");
    bus_access(0, 1'b1, make_addr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CTRL), 32'd1, rd, err,
               lat, ack_at, end_at);
    check_flag("timer enable err", 1'b0, err);
    check_flag("timer intr below compare", 1'b0, intr_timer);
    prev = '0;
    for (int i = 0; i < 3; i++) begin
      read_word(1, make_addr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_COUNT), "timer count", cnt);
      if (cnt < prev) begin
        report_problem($sformatf("timer count went backwards from %0d to %0d", prev, cnt));
      end
      prev = cnt;
    end
    waited = cycle_cnt - ack_at;
    while (!intr_timer && waited <= TIMER_N + 10) begin
      @(negedge clk);
      waited = cycle_cnt - ack_at;
    end
    if (!intr_timer) begin
      report_problem($sformatf("timer interrupt did not rise within %0d cycles of the enable",
                               TIMER_N + 10));
    end
    write_word(1, make_addr(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CTRL), 32'd0, "timer off");
    check_flag("timer intr after disable", 1'b0, intr_timer);
  endtask

  initial begin
    rst_n        = 1'b0;
    h0_req       = 1'b0;
    h0_we        = 1'b0;
    h0_addr      = '0;
    h0_wdata     = '0;
    h1_req       = 1'b0;
    h1_we        = 1'b0;
    h1_addr      = '0;
    h1_wdata     = '0;
    gpio_in      = '0;
    lfsr_state   = 16'd60660;
    value_errors = 0;
    other_errors = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_state();
    test_arbitration();
    test_memory();
    test_unmapped();
    test_gpio();
    test_timer();
    @(posedge clk);
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 4
) (
  output logic clk_o
);

  // free-running clock, low for the first half period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

// File: verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
  parameter int DMEM_WORDS = 256,
  parameter int GPIO_WIDTH = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        h0_req_i,
  input  logic                        h0_we_i,
  input  logic [31:0]                 h0_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]  h0_wdata_i,
  output logic                        h0_ack_o,
  output logic [soc_pkg::DATA_W-1:0]  h0_rdata_o,
  output logic                        h0_err_o,

  input  logic                        h1_req_i,
  input  logic                        h1_we_i,
  input  logic [31:0]                 h1_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]  h1_wdata_i,
  output logic                        h1_ack_o,
  output logic [soc_pkg::DATA_W-1:0]  h1_rdata_o,
  output logic                        h1_err_o,

  input  logic [GPIO_WIDTH-1:0]       gpio_i,
  output logic [GPIO_WIDTH-1:0]       gpio_o,
  output logic [GPIO_WIDTH-1:0]       gpio_oe_o,
  output logic                        intr_gpio_o,
  output logic                        intr_timer_o
);

  // shared system bus
  logic                       bus_req;
  logic                       bus_we;
  logic [31:0]                bus_addr;
  logic [soc_pkg::DATA_W-1:0] bus_wdata;
  logic                       bus_ack;
  logic [soc_pkg::DATA_W-1:0] bus_rdata;
  logic                       bus_err;

  // device links
  logic                       dmem_req;
  logic                       dmem_we;
  logic [7:0]                 dmem_index;
  logic [soc_pkg::DATA_W-1:0] dmem_wdata;
  logic                       dmem_ack;
  logic [soc_pkg::DATA_W-1:0] dmem_rdata;
  logic                       gpio_req;
  logic                       gpio_we;
  logic [7:0]                 gpio_index;
  logic [soc_pkg::DATA_W-1:0] gpio_wdata;
  logic                       gpio_ack;
  logic [soc_pkg::DATA_W-1:0] gpio_rdata;
  logic                       tmr_req;
  logic                       tmr_we;
  logic [7:0]                 tmr_index;
  logic [soc_pkg::DATA_W-1:0] tmr_wdata;
  logic                       tmr_ack;
  logic [soc_pkg::DATA_W-1:0] tmr_rdata;

  bus_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .h0_req_i    (h0_req_i),
    .h0_we_i     (h0_we_i),
    .h0_addr_i   (h0_addr_i),
    .h0_wdata_i  (h0_wdata_i),
    .h0_ack_o    (h0_ack_o),
    .h0_rdata_o  (h0_rdata_o),
    .h0_err_o    (h0_err_o),
    .h1_req_i    (h1_req_i),
    .h1_we_i     (h1_we_i),
    .h1_addr_i   (h1_addr_i),
    .h1_wdata_i  (h1_wdata_i),
    .h1_ack_o    (h1_ack_o),
    .h1_rdata_o  (h1_rdata_o),
    .h1_err_o    (h1_err_o),
    .bus_req_o   (bus_req),
    .bus_we_o    (bus_we),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_ack_i   (bus_ack),
    .bus_rdata_i (bus_rdata),
    .bus_err_i   (bus_err)
  );

  bus_decoder u_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bus_req_i    (bus_req),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_ack_o    (bus_ack),
    .bus_rdata_o  (bus_rdata),
    .bus_err_o    (bus_err),
    .dmem_req_o   (dmem_req),
    .dmem_we_o    (dmem_we),
    .dmem_index_o (dmem_index),
    .dmem_wdata_o (dmem_wdata),
    .dmem_ack_i   (dmem_ack),
    .dmem_rdata_i (dmem_rdata),
    .gpio_req_o   (gpio_req),
    .gpio_we_o    (gpio_we),
    .gpio_index_o (gpio_index),
    .gpio_wdata_o (gpio_wdata),
    .gpio_ack_i   (gpio_ack),
    .gpio_rdata_i (gpio_rdata),
    .tmr_req_o    (tmr_req),
    .tmr_we_o     (tmr_we),
    .tmr_index_o  (tmr_index),
    .tmr_wdata_o  (tmr_wdata),
    .tmr_ack_i    (tmr_ack),
    .tmr_rdata_i  (tmr_rdata)
  );

  data_mem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dmem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (dmem_req),
    .we_i    (dmem_we),
    .index_i (dmem_index),
    .wdata_i (dmem_wdata),
    .ack_o   (dmem_ack),
    .rdata_o (dmem_rdata)
  );

  gpio #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) u_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (gpio_req),
    .we_i      (gpio_we),
    .index_i   (gpio_index),
    .wdata_i   (gpio_wdata),
    .ack_o     (gpio_ack),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .intr_o    (intr_gpio_o)
  );

  rv_timer u_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (tmr_req),
    .we_i    (tmr_we),
    .index_i (tmr_index),
    .wdata_i (tmr_wdata),
    .ack_o   (tmr_ack),
    .rdata_o (tmr_rdata),
    .intr_o  (intr_timer_o)
  );

endmodule

// File: verilog/rv_timer.sv
`timescale 1ns/1ps

module rv_timer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [7:0]                  index_i,
  input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
  output logic                        ack_o,
  output logic [soc_pkg::DATA_W-1:0]  rdata_o,
  output logic                        intr_o
);

  logic [soc_pkg::DATA_W-1:0] count_q;
  logic [soc_pkg::DATA_W-1:0] compare_q;
  logic [soc_pkg::DATA_W-1:0] rd_word;
  logic [soc_pkg::DATA_W-1:0] rdata_q;
  logic                       en_q;
  logic                       ack_q;
  logic                       start;
  logic                       wr;

  assign start = req_i & ~ack_q;
  assign wr    = start & we_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      en_q      <= 1'b0;
      count_q   <= '0;
      compare_q <= '1;
    end else begin
      ack_q <= req_i;
      if (wr && index_i == soc_pkg::TIMER_CTRL) begin
        en_q <= wdata_i[0];
      end
      // a bus load takes priority over counting
      if (wr && index_i == soc_pkg::TIMER_COUNT) begin
        count_q <= wdata_i;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr && index_i == soc_pkg::TIMER_COMPARE) begin
        compare_q <= wdata_i;
      end
    end
  end

  always_comb begin
    case (index_i)
      soc_pkg::TIMER_CTRL:    rd_word = soc_pkg::DATA_W'(en_q);
      soc_pkg::TIMER_COUNT:   rd_word = count_q;
      soc_pkg::TIMER_COMPARE: rd_word = compare_q;
      default:                rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (start && !we_i) begin
      rdata_q <= rd_word;
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;
  // level interrupt, held while the count sits at or past compare
  assign intr_o  = en_q & (count_q >= compare_q);

endmodule

// File: verilog/gpio.sv
`timescale 1ns/1ps

module gpio #(
  parameter int GPIO_WIDTH = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [7:0]                  index_i,
  input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
  output logic                        ack_o,
  output logic [soc_pkg::DATA_W-1:0]  rdata_o,
  input  logic [GPIO_WIDTH-1:0]       gpio_i,
  output logic [GPIO_WIDTH-1:0]       gpio_o,
  output logic [GPIO_WIDTH-1:0]       gpio_oe_o,
  output logic                        intr_o
);

  logic [GPIO_WIDTH-1:0]      in_q;
  logic [GPIO_WIDTH-1:0]      out_q;
  logic [GPIO_WIDTH-1:0]      oe_q;
  logic [GPIO_WIDTH-1:0]      state_q;
  logic [GPIO_WIDTH-1:0]      en_q;
  logic [GPIO_WIDTH-1:0]      rise;
  logic [GPIO_WIDTH-1:0]      clr;
  logic [GPIO_WIDTH-1:0]      wr_val;
  logic [soc_pkg::DATA_W-1:0] rd_word;
  logic [soc_pkg::DATA_W-1:0] rdata_q;
  logic                       ack_q;
  logic                       start;

  assign start  = req_i & ~ack_q;
  assign wr_val = wdata_i[GPIO_WIDTH-1:0];
  assign rise   = gpio_i & ~in_q;
  // write one to clear
  assign clr    = (start && we_i && index_i == soc_pkg::GPIO_INTR_STATE) ? wr_val : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      in_q    <= '0;
      out_q   <= '0;
      oe_q    <= '0;
      state_q <= '0;
      en_q    <= '0;
    end else begin
      ack_q   <= req_i;
      in_q    <= gpio_i;
      // a new edge wins over a clear in the same cycle
      state_q <= (state_q & ~clr) | rise;
      if (start && we_i) begin
        case (index_i)
          soc_pkg::GPIO_DATA_OUT:    out_q <= wr_val;
          soc_pkg::GPIO_OE:          oe_q  <= wr_val;
          soc_pkg::GPIO_INTR_ENABLE: en_q  <= wr_val;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (index_i)
      soc_pkg::GPIO_DATA_IN:     rd_word = soc_pkg::DATA_W'(in_q);
      soc_pkg::GPIO_DATA_OUT:    rd_word = soc_pkg::DATA_W'(out_q);
      soc_pkg::GPIO_OE:          rd_word = soc_pkg::DATA_W'(oe_q);
      soc_pkg::GPIO_INTR_STATE:  rd_word = soc_pkg::DATA_W'(state_q);
      soc_pkg::GPIO_INTR_ENABLE: rd_word = soc_pkg::DATA_W'(en_q);
      default:                   rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (start && !we_i) begin
      rdata_q <= rd_word;
    end
  end

  assign ack_o     = ack_q;
  assign rdata_o   = rdata_q;
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = |(state_q & en_q);

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
  parameter int DMEM_WORDS = 256
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [7:0]                  index_i,
  input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
  output logic                        ack_o,
  output logic [soc_pkg::DATA_W-1:0]  rdata_o
);

  localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

  logic [soc_pkg::DATA_W-1:0] mem_q [DMEM_WORDS];
  logic [soc_pkg::DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]           widx;
  logic                       ack_q;
  logic                       start;

  // index wraps around the memory size
  assign widx  = IDX_W'(32'(index_i) % DMEM_WORDS);
  assign start = req_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  // access happens in the cycle ack rises
  always_ff @(posedge clk_i) begin
    if (start) begin
      if (we_i) begin
        mem_q[widx] <= wdata_i;
      end else begin
        rdata_q <= mem_q[widx];
      end
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

endmodule

// File: verilog/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        bus_req_i,
  input  logic                        bus_we_i,
  input  logic [31:0]                 bus_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]  bus_wdata_i,
  output logic                        bus_ack_o,
  output logic [soc_pkg::DATA_W-1:0]  bus_rdata_o,
  output logic                        bus_err_o,

  output logic                        dmem_req_o,
  output logic                        dmem_we_o,
  output logic [7:0]                  dmem_index_o,
  output logic [soc_pkg::DATA_W-1:0]  dmem_wdata_o,
  input  logic                        dmem_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]  dmem_rdata_i,

  output logic                        gpio_req_o,
  output logic                        gpio_we_o,
  output logic [7:0]                  gpio_index_o,
  output logic [soc_pkg::DATA_W-1:0]  gpio_wdata_o,
  input  logic                        gpio_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]  gpio_rdata_i,

  output logic                        tmr_req_o,
  output logic                        tmr_we_o,
  output logic [7:0]                  tmr_index_o,
  output logic [soc_pkg::DATA_W-1:0]  tmr_wdata_o,
  input  logic                        tmr_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]  tmr_rdata_i
);

  soc_pkg::bus_addr_u addr;
  logic sel_dmem;
  logic sel_gpio;
  logic sel_tmr;
  logic sel_none;
  logic err_ack_q;

  assign addr.raw = bus_addr_i;

  always_comb begin
    sel_dmem = 1'b0;
    sel_gpio = 1'b0;
    sel_tmr  = 1'b0;
    sel_none = 1'b0;
    case (addr.field.region)
      soc_pkg::REGION_DMEM:  sel_dmem = 1'b1;
      soc_pkg::REGION_GPIO:  sel_gpio = 1'b1;
      soc_pkg::REGION_TIMER: sel_tmr  = 1'b1;
      default:               sel_none = 1'b1;
    endcase
  end

  assign dmem_req_o   = bus_req_i & sel_dmem;
  assign dmem_we_o    = bus_we_i;
  assign dmem_index_o = addr.field.index;
  assign dmem_wdata_o = bus_wdata_i;
  assign gpio_req_o   = bus_req_i & sel_gpio;
  assign gpio_we_o    = bus_we_i;
  assign gpio_index_o = addr.field.index;
  assign gpio_wdata_o = bus_wdata_i;
  assign tmr_req_o    = bus_req_i & sel_tmr;
  assign tmr_we_o     = bus_we_i;
  assign tmr_index_o  = addr.field.index;
  assign tmr_wdata_o  = bus_wdata_i;

  // error responder for unmapped regions
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= bus_req_i & sel_none;
    end
  end

  // at most one responder acks at a time, so select on ack and not on address
  assign bus_ack_o = dmem_ack_i | gpio_ack_i | tmr_ack_i | err_ack_q;
  assign bus_err_o = err_ack_q;

  always_comb begin
    if (dmem_ack_i) begin
      bus_rdata_o = dmem_rdata_i;
    end else if (gpio_ack_i) begin
      bus_rdata_o = gpio_rdata_i;
    end else if (tmr_ack_i) begin
      bus_rdata_o = tmr_rdata_i;
    end else begin
      bus_rdata_o = '0;
    end
  end

endmodule

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // host 0, core data port
  input  logic                        h0_req_i,
  input  logic                        h0_we_i,
  input  logic [31:0]                 h0_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]  h0_wdata_i,
  output logic                        h0_ack_o,
  output logic [soc_pkg::DATA_W-1:0]  h0_rdata_o,
  output logic                        h0_err_o,

  // host 1, debug system bus port
  input  logic                        h1_req_i,
  input  logic                        h1_we_i,
  input  logic [31:0]                 h1_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]  h1_wdata_i,
  output logic                        h1_ack_o,
  output logic [soc_pkg::DATA_W-1:0]  h1_rdata_o,
  output logic                        h1_err_o,

  // shared bus towards the decoder
  output logic                        bus_req_o,
  output logic                        bus_we_o,
  output logic [31:0]                 bus_addr_o,
  output logic [soc_pkg::DATA_W-1:0]  bus_wdata_o,
  input  logic                        bus_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]  bus_rdata_i,
  input  logic                        bus_err_i
);

  logic gnt_valid_q;
  logic gnt_q;
  logic last_q;
  logic bus_req_q;
  logic gnt_req;
  logic done;
  logic free;
  logic any_req;
  logic winner;
  logic h0_sel;
  logic h1_sel;

  assign gnt_req = gnt_q ? h1_req_i : h0_req_i;
  // transaction closed once req went low and the device dropped ack
  assign done    = gnt_valid_q & ~bus_req_q & ~bus_ack_i;
  assign free    = ~gnt_valid_q | done;
  assign any_req = h0_req_i | h1_req_i;
  // on a tie the host not served last wins
  assign winner  = (h0_req_i & h1_req_i) ? ~last_q : h1_req_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gnt_valid_q <= 1'b0;
      gnt_q       <= 1'b0;
      last_q      <= 1'b0;
      bus_req_q   <= 1'b0;
    end else if (free) begin
      gnt_valid_q <= any_req;
      bus_req_q   <= any_req;
      if (any_req) begin
        gnt_q  <= winner;
        last_q <= winner;
      end
    end else if (bus_req_q) begin
      // once low, req stays low until the grant is released
      bus_req_q <= gnt_req;
    end
  end

  assign h0_sel = gnt_valid_q & ~gnt_q;
  assign h1_sel = gnt_valid_q & gnt_q;

  assign bus_req_o   = bus_req_q;
  assign bus_we_o    = gnt_q ? h1_we_i : h0_we_i;
  assign bus_addr_o  = gnt_q ? h1_addr_i : h0_addr_i;
  assign bus_wdata_o = gnt_q ? h1_wdata_i : h0_wdata_i;

  // response goes back to the granted host only
  assign h0_ack_o   = h0_sel & bus_ack_i;
  assign h0_err_o   = h0_sel & bus_err_i;
  assign h0_rdata_o = h0_sel ? bus_rdata_i : '0;
  assign h1_ack_o   = h1_sel & bus_ack_i;
  assign h1_err_o   = h1_sel & bus_err_i;
  assign h1_rdata_o = h1_sel ? bus_rdata_i : '0;

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

  // width of every bus data word
  localparam int DATA_W = 32;

  // system bus address, seen as a raw word or split into fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [3:0]  region;
      logic [17:0] reserved;
      logic [7:0]  index;
      logic [1:0]  offset;
    } field;
  } bus_addr_u;

  // region codes in the top nibble, anything else is unmapped
  localparam logic [3:0] REGION_DMEM  = 4'h0;
  localparam logic [3:0] REGION_GPIO  = 4'h4;
  localparam logic [3:0] REGION_TIMER = 4'h5;

  // gpio register word indices
  localparam logic [7:0] GPIO_DATA_IN     = 8'd0;
  localparam logic [7:0] GPIO_DATA_OUT    = 8'd1;
  localparam logic [7:0] GPIO_OE          = 8'd2;
  localparam logic [7:0] GPIO_INTR_STATE  = 8'd3;
  localparam logic [7:0] GPIO_INTR_ENABLE = 8'd4;

  // timer register word indices
  localparam logic [7:0] TIMER_CTRL    = 8'd0;
  localparam logic [7:0] TIMER_COUNT   = 8'd1;
  localparam logic [7:0] TIMER_COMPARE = 8'd2;

endpackage
